/* Bender.yml */
package:
  name: fmb_tester

sources:
  - files:
      - source/fmb_pkg.sv
      - source/ddr_reset_sequencer.sv
      - source/mem_check_seq.sv
      - source/mem_check_writer.sv
      - source/mem_check_reader.sv
      - source/fmb_tester_top.sv
  - target: simulation
    files:
      - sim/tb_axi_mem_model.sv
      - sim/tb_fmb_tester.sv

/* sim/tb_axi_mem_model.sv */
// LPDDR4x controller model: config done, burst memory, random stalls and fault injection
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_model (
	input  logic                        iSCLK,
	input  logic                        i_cfg_start,
	output logic                        o_cfg_done,
	input  fmb_pkg::addr_t              i_awaddr,
	input  logic [fmb_pkg::AXLEN_W-1:0] i_awlen,
	input  logic                        i_awvalid,
	output logic                        o_awready,
	input  fmb_pkg::data_t              i_wdata,
	input  logic [fmb_pkg::STRB_W-1:0]  i_wstrb,
	input  logic                        i_wlast,
	input  logic                        i_wvalid,
	output logic                        o_wready,
	output logic [fmb_pkg::RESP_W-1:0]  o_bresp,
	output logic                        o_bvalid,
	input  logic                        i_bready,
	input  fmb_pkg::addr_t              i_araddr,
	input  logic [fmb_pkg::AXLEN_W-1:0] i_arlen,
	input  logic                        i_arvalid,
	output logic                        o_arready,
	output fmb_pkg::data_t              o_rdata,
	output logic [fmb_pkg::RESP_W-1:0]  o_rresp,
	output logic                        o_rlast,
	output logic                        o_rvalid,
	input  logic                        i_rready,
	input  int                          i_corrupt_idx,
	input  int                          i_bad_burst,
	output logic                        o_bus_err
);
	import fmb_pkg::*;

	// calibration time in clocks after cfg_start
	localparam int DONE_DELAY = 12;
	// eight-beat bursts, axi len field is beats minus one
	localparam logic [AXLEN_W-1:0] EXP_AXLEN = 8'd7;
	// every write covers the full word
	localparam logic [STRB_W-1:0] EXP_WSTRB = 4'hf;

	data_t mem [0:TEST_WORDS-1];
	logic [31:0] lfsr;
	logic [15:0] exp_idx;
	int cfg_cnt;
	int wr_idx;
	int wr_burst;
	int rd_idx;
	int rd_left;
	logic b_issue;
	logic b_take;
	logic r_take;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	initial
	begin
		lfsr = 32'h61bd_8e18;
		cfg_cnt = 0;
		rd_left = 0;
		rd_idx = 0;
		o_cfg_done = 1'b0;
		o_awready = 1'b0;
		o_wready = 1'b0;
		o_bresp = '0;
		o_bvalid = 1'b0;
		o_arready = 1'b0;
		o_rdata = '0;
		o_rresp = '0;
		o_rlast = 1'b0;
		o_rvalid = 1'b0;
		o_bus_err = 1'b0;
	end

	// ------------------------------------------------------------
	// sample at the edge, drive 1 ns later
	// ------------------------------------------------------------
	always @(posedge iSCLK)
	begin
		b_issue = 1'b0;
		b_take = o_bvalid && i_bready;
		r_take = o_rvalid && i_rready;
		if (i_cfg_start)
			cfg_cnt++;
		if (i_awvalid && o_awready)
		begin
			wr_idx = int'(i_awaddr >> 2);
			wr_burst = wr_idx / BURST_LEN;
			if (i_awlen !== EXP_AXLEN)
			begin
				$display("mismatch at %0t ns: awlen %0d at word %0d", $time, i_awlen, wr_idx);
				o_bus_err = 1'b1;
			end
		end
		if (i_wvalid && o_wready)
		begin
			// index in the low half, its inverse above
			exp_idx = 16'(wr_idx);
			if (i_wdata !== {~exp_idx, exp_idx})
			begin
				$display("mismatch at %0t ns: word %0d written as %h", $time, wr_idx, i_wdata);
				o_bus_err = 1'b1;
			end
			if (i_wstrb !== EXP_WSTRB)
			begin
				$display("mismatch at %0t ns: wstrb %b on word %0d", $time, i_wstrb, wr_idx);
				o_bus_err = 1'b1;
			end
			if (i_wlast !== ((wr_idx % BURST_LEN) == BURST_LEN - 1))
			begin
				$display("mismatch at %0t ns: wlast wrong on word %0d", $time, wr_idx);
				o_bus_err = 1'b1;
			end
			// injected fault, one stored bit flipped
			if (wr_idx == i_corrupt_idx)
				mem[wr_idx % TEST_WORDS] = i_wdata ^ 32'h0000_0100;
			else
				mem[wr_idx % TEST_WORDS] = i_wdata;
			b_issue = i_wlast;
			wr_idx++;
		end
		if (i_arvalid && o_arready)
		begin
			rd_idx = int'(i_araddr >> 2);
			rd_left = BURST_LEN;
			if (i_arlen !== EXP_AXLEN)
			begin
				$display("mismatch at %0t ns: arlen %0d at word %0d", $time, i_arlen, rd_idx);
				o_bus_err = 1'b1;
			end
		end
		if (r_take)
		begin
			rd_idx++;
			rd_left--;
		end

		#1;
		o_cfg_done = o_cfg_done | (cfg_cnt >= DONE_DELAY);
		if (b_take)
			o_bvalid = 1'b0;
		if (b_issue)
		begin
			o_bvalid = 1'b1;
			o_bresp = (wr_burst == i_bad_burst) ? 2'b10 : 2'b00;
		end
		// one lfsr step per stall bit
		lfsr = lfsr_step(lfsr);
		o_awready = lfsr[0];
		lfsr = lfsr_step(lfsr);
		o_wready = lfsr[0];
		lfsr = lfsr_step(lfsr);
		o_arready = lfsr[0];
		// a raised rvalid stays up until taken
		if (rd_left == 0)
			o_rvalid = 1'b0;
		else if (!o_rvalid || r_take)
		begin
			lfsr = lfsr_step(lfsr);
			o_rvalid = lfsr[0];
		end
		o_rdata = mem[rd_idx % TEST_WORDS];
		o_rlast = (rd_left == 1);
	end

endmodule

`default_nettype wire

/* sim/tb_fmb_tester.sv */
// memory tester testbench: config sequence, fault case table, status and LED checks
`timescale 1ns/1ps
`default_nettype none

module tb_fmb_tester;
	import fmb_pkg::*;

	localparam int NO_FAULT = -1;
	localparam int N_CASES = 6;
	localparam int WAIT_CFG = 200;
	localparam int WAIT_SHORT = 20;
	localparam int WAIT_TEST = 4000;

	// wait selectors
	localparam int SEL_CFG_RESET = 0;
	localparam int SEL_CFG_START = 1;
	localparam int SEL_AXI_RSTN = 2;
	localparam int SEL_RUN = 3;
	localparam int SEL_DONE = 4;

	typedef struct packed {
		int corrupt_idx;
		int bad_burst;
		logic exp_fail;
		addr_t exp_addr;
	} case_t;

	case_t cases [0:N_CASES-1];

	logic iSCLK;
	logic pll_bl1_locked;
	logic pll_tl2_locked;
	logic [1:0] pb_sw;
	logic cfg_done;
	logic cfg_reset;
	logic cfg_start;
	logic axi_rstn;
	addr_t awaddr;
	logic [AXLEN_W-1:0] awlen;
	logic awvalid;
	logic awready;
	data_t wdata;
	logic [STRB_W-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [RESP_W-1:0] bresp;
	logic bvalid;
	logic bready;
	addr_t araddr;
	logic [AXLEN_W-1:0] arlen;
	logic arvalid;
	logic arready;
	data_t rdata;
	logic [RESP_W-1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;
	logic [7:2] led;
	addr_t fail_addr;
	int corrupt_idx;
	int bad_burst;
	logic bus_err;

	fmb_tester_top u_dut (
		.iSCLK (iSCLK), .i_pll_bl1_locked (pll_bl1_locked),
		.i_pll_tl2_locked (pll_tl2_locked), .i_pb_sw (pb_sw),
		.i_ddr_cfg_done (cfg_done), .o_ddr_cfg_reset (cfg_reset),
		.o_ddr_cfg_start (cfg_start), .o_ddr_axi_rstn (axi_rstn),
		.o_awaddr (awaddr), .o_awlen (awlen), .o_awvalid (awvalid), .i_awready (awready),
		.o_wdata (wdata), .o_wstrb (wstrb), .o_wlast (wlast),
		.o_wvalid (wvalid), .i_wready (wready),
		.i_bresp (bresp), .i_bvalid (bvalid), .o_bready (bready),
		.o_araddr (araddr), .o_arlen (arlen), .o_arvalid (arvalid), .i_arready (arready),
		.i_rdata (rdata), .i_rresp (rresp), .i_rlast (rlast),
		.i_rvalid (rvalid), .o_rready (rready),
		.o_led (led), .o_fail_addr (fail_addr)
	);

	tb_axi_mem_model u_mem (
		.iSCLK (iSCLK), .i_cfg_start (cfg_start), .o_cfg_done (cfg_done),
		.i_awaddr (awaddr), .i_awlen (awlen), .i_awvalid (awvalid), .o_awready (awready),
		.i_wdata (wdata), .i_wstrb (wstrb), .i_wlast (wlast),
		.i_wvalid (wvalid), .o_wready (wready),
		.o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
		.i_araddr (araddr), .i_arlen (arlen), .i_arvalid (arvalid), .o_arready (arready),
		.o_rdata (rdata), .o_rresp (rresp), .o_rlast (rlast),
		.o_rvalid (rvalid), .i_rready (rready),
		.i_corrupt_idx (corrupt_idx), .i_bad_burst (bad_burst), .o_bus_err (bus_err)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #2 iSCLK = ~iSCLK;
	end

	// ------------------------------------------------------------
	// reporting and compare tasks
	// ------------------------------------------------------------
	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_led(input logic [7:2] got, input logic [7:2] exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s are %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// any bad transfer seen by the memory model ends the run
	always @(posedge bus_err)
	begin
		$display("the memory model saw a bad AXI transfer");
		abort_run();
	end

	function automatic logic probe(input int sel);
		case (sel)
			SEL_CFG_RESET: return cfg_reset;
			SEL_CFG_START: return cfg_start;
			SEL_AXI_RSTN: return axi_rstn;
			SEL_RUN: return led[5];
			default: return led[7];
		endcase
	endfunction

	// polled 1 ns after each edge
	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while (probe(sel) !== level)
		begin
			if (n == limit)
			begin
				$display("timeout: no %s within %0d clocks", what, limit);
				abort_run();
			end
			@(posedge iSCLK);
			#1;
			n++;
		end
	endtask

	task automatic press_restart();
		pb_sw[1] = 1'b0;
		repeat (4) @(posedge iSCLK);
		#1;
		pb_sw[1] = 1'b1;
	endtask

	task automatic check_result(input logic exp_fail, input addr_t exp_addr);
		// done, fail, run low, ready, start low, locked
		check_led(led, {1'b1, exp_fail, 1'b0, 1'b1, 1'b0, 1'b1}, "LEDs at test end");
		check_addr(fail_addr, exp_addr, "first fail address");
	endtask

	task automatic add_case(input int n, input int cw, input int bb, input logic f,
		input addr_t a);
		cases[n].corrupt_idx = cw;
		cases[n].bad_burst = bb;
		cases[n].exp_fail = f;
		cases[n].exp_addr = a;
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		pb_sw = 2'b11;
		pll_bl1_locked = 1'b0;
		pll_tl2_locked = 1'b0;
		corrupt_idx = NO_FAULT;
		bad_burst = NO_FAULT;
		// expected address is the corrupt word, or the bad burst base
		add_case(0, NO_FAULT, NO_FAULT, 1'b0, '0);
		add_case(1, 29, NO_FAULT, 1'b1, TEST_BASE + addr_t'(29 * 4));
		add_case(2, NO_FAULT, 5, 1'b1, TEST_BASE + addr_t'(5 * 32));
		add_case(3, 3, 6, 1'b1, TEST_BASE + addr_t'(6 * 32));
		add_case(4, NO_FAULT, NO_FAULT, 1'b0, '0);
		add_case(5, 63, NO_FAULT, 1'b1, TEST_BASE + addr_t'(63 * 4));
		repeat (2) @(posedge iSCLK);
		#1;
		check_led(led, 6'b000000, "LEDs in reset");
		pll_bl1_locked = 1'b1;
		pll_tl2_locked = 1'b1;
		@(posedge iSCLK);
		#1;
		check_led(led, 6'b000001, "LEDs after reset release");
		check_bit(cfg_reset, 1'b0, "cfg_reset after reset");
		check_bit(cfg_start, 1'b0, "cfg_start after reset");
		check_bit(axi_rstn, 1'b0, "axi_rstn after reset");

		// config order: reset, start, then axi reset release
		wait_level(SEL_CFG_RESET, 1'b1, WAIT_CFG, "config reset");
		check_bit(cfg_start, 1'b0, "cfg_start during config reset");
		wait_level(SEL_CFG_START, 1'b1, WAIT_CFG, "config start");
		check_bit(cfg_reset, 1'b0, "cfg_reset during config start");
		check_bit(axi_rstn, 1'b0, "axi_rstn before cfg_done");
		check_led(led, 6'b000011, "LEDs during config start");
		wait_level(SEL_AXI_RSTN, 1'b1, WAIT_CFG, "AXI reset release");
		check_bit(cfg_done, 1'b1, "cfg_done at AXI reset release");
		check_bit(cfg_start, 1'b0, "cfg_start after config");

		// first run starts by itself once config is ready
		wait_level(SEL_DONE, 1'b1, WAIT_TEST, "end of the first test");
		check_result(1'b0, '0);

		for (int i = 0; i < N_CASES; i++)
		begin
			corrupt_idx = cases[i].corrupt_idx;
			bad_burst = cases[i].bad_burst;
			press_restart();
			wait_level(SEL_DONE, 1'b0, WAIT_SHORT, "done to clear on restart");
			check_bit(led[6], 1'b0, "fail after restart");
			check_addr(fail_addr, '0, "fail address after restart");
			wait_level(SEL_RUN, 1'b1, WAIT_SHORT, "test run after restart");
			check_led(led, 6'b001101, "LEDs while running");
			wait_level(SEL_DONE, 1'b1, WAIT_TEST, "end of the test");
			check_result(cases[i].exp_fail, cases[i].exp_addr);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* source/ddr_reset_sequencer.sv */
// ddr controller config sequencer: config reset hold, start until done, axi reset release
`timescale 1ns/1ps
`default_nettype none

module ddr_reset_sequencer (
	input  logic iSCLK,
	input  logic qLocked,
	input  logic i_ddr_cfg_done,
	output logic o_ddr_cfg_reset,
	output logic o_ddr_cfg_start,
	output logic o_ddr_axi_rstn,
	output logic o_cfg_ready
);
	import fmb_pkg::*;

	logic [1:0] rst_sync;
	logic [CFG_CNT_W-1:0] hold_cnt;
	rst_state_e state;

	// ------------------------------------------------------------
	// reset release synchronizer
	// ------------------------------------------------------------
	// assert at once, release two clocks later
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
			rst_sync <= 2'b00;
		else
			rst_sync <= {rst_sync[0], 1'b1};
	end

	// ------------------------------------------------------------
	// config FSM
	// ------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state <= RS_HOLD;
			hold_cnt <= '0;
		end
		else
		begin
			case (state)
				RS_HOLD:
				begin
					hold_cnt <= '0;
					if (rst_sync[1])
						state <= RS_CFG_RESET;
				end
				// config reset for CFG_RST_CYCLES clocks
				RS_CFG_RESET:
				begin
					hold_cnt <= hold_cnt + 1'b1;
					if (hold_cnt == CFG_CNT_W'(CFG_RST_CYCLES - 1))
						state <= RS_CFG_START;
				end
				// start held until the controller reports calibration done
				RS_CFG_START:
				begin
					if (i_ddr_cfg_done)
						state <= RS_READY;
				end
				// stays here until the next reset
				default:
					state <= RS_READY;
			endcase
		end
	end

	// outputs decoded straight from the state register
	assign o_ddr_cfg_reset = (state == RS_CFG_RESET);
	assign o_ddr_cfg_start = (state == RS_CFG_START);
	assign o_ddr_axi_rstn = (state == RS_READY);
	assign o_cfg_ready = (state == RS_READY);

endmodule

`default_nettype wire

/* source/fmb_pkg.sv */
// fmb memory tester package: bus geometry, test region, FSM states and data pattern
`default_nettype none

package fmb_pkg;

	// ------------------------------------------------------------
	// axi port geometry
	// ------------------------------------------------------------
	localparam int ADDR_W = 33;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int AXLEN_W = 8;
	localparam int RESP_W = 2;
	localparam int HALF_W = DATA_W / 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// ------------------------------------------------------------
	// test region and burst shape
	// ------------------------------------------------------------
	localparam int BURST_LEN = 8;
	localparam int BEAT_CNT_W = $clog2(BURST_LEN);
	// one beat moves one full data word
	localparam int BEAT_BYTES = STRB_W;
	localparam int BURST_BYTES = BURST_LEN * BEAT_BYTES;
	localparam int TEST_WORDS = 64;
	localparam int TEST_BURSTS = TEST_WORDS / BURST_LEN;
	localparam int BURST_CNT_W = $clog2(TEST_BURSTS);
	localparam addr_t TEST_BASE = '0;

	// controller config reset hold
	localparam int CFG_RST_CYCLES = 16;
	localparam int CFG_CNT_W = $clog2(CFG_RST_CYCLES);

	// reset / config sequencer
	typedef enum logic [1:0] {
		RS_HOLD,
		RS_CFG_RESET,
		RS_CFG_START,
		RS_READY
	} rst_state_e;

	// test sequencer, one burst in flight at a time
	typedef enum logic [2:0] {
		TS_IDLE,
		TS_WR_ISSUE,
		TS_WR_WAIT,
		TS_RD_ISSUE,
		TS_RD_WAIT,
		TS_DONE
	} test_state_e;

	// word index in the low half, its inverse in the high half
	function automatic data_t pattern_of(input addr_t addr);
		logic [HALF_W-1:0] idx;
		idx = HALF_W'(addr >> 2);
		return {~idx, idx};
	endfunction

endpackage

`default_nettype wire

/* source/fmb_tester_top.sv */
// fmb memory tester top: reset forming, config sequencer, test engine and status LEDs
`timescale 1ns/1ps
`default_nettype none

module fmb_tester_top (
	// clock and board controls
	input  logic                        iSCLK,
	input  logic                        i_pll_bl1_locked,
	input  logic                        i_pll_tl2_locked,
	input  logic [1:0]                  i_pb_sw,
	// controller configuration
	input  logic                        i_ddr_cfg_done,
	output logic                        o_ddr_cfg_reset,
	output logic                        o_ddr_cfg_start,
	output logic                        o_ddr_axi_rstn,
	// axi write address / data / response
	output fmb_pkg::addr_t              o_awaddr,
	output logic [fmb_pkg::AXLEN_W-1:0] o_awlen,
	output logic                        o_awvalid,
	input  logic                        i_awready,
	output fmb_pkg::data_t              o_wdata,
	output logic [fmb_pkg::STRB_W-1:0]  o_wstrb,
	output logic                        o_wlast,
	output logic                        o_wvalid,
	input  logic                        i_wready,
	input  logic [fmb_pkg::RESP_W-1:0]  i_bresp,
	input  logic                        i_bvalid,
	output logic                        o_bready,
	// axi read address / data
	output fmb_pkg::addr_t              o_araddr,
	output logic [fmb_pkg::AXLEN_W-1:0] o_arlen,
	output logic                        o_arvalid,
	input  logic                        i_arready,
	input  fmb_pkg::data_t              i_rdata,
	input  logic [fmb_pkg::RESP_W-1:0]  i_rresp,
	input  logic                        i_rlast,
	input  logic                        i_rvalid,
	output logic                        o_rready,
	// status
	output logic [7:2]                  o_led,
	output fmb_pkg::addr_t              o_fail_addr
);
	import fmb_pkg::*;

	logic qLocked;
	logic cfg_ready;
	logic wr_start, rd_start;
	logic wr_done, wr_bad;
	logic rd_done, rd_mismatch;
	logic test_run, test_done, test_fail;
	addr_t burst_base;
	addr_t rd_mismatch_addr;

	// ------------------------------------------------------------
	// system reset, switch 0 and both PLLs locked
	// ------------------------------------------------------------
	assign qLocked = i_pb_sw[0] & i_pll_bl1_locked & i_pll_tl2_locked;

	ddr_reset_sequencer u_rst_seq (
		.iSCLK           (iSCLK),
		.qLocked         (qLocked),
		.i_ddr_cfg_done  (i_ddr_cfg_done),
		.o_ddr_cfg_reset (o_ddr_cfg_reset),
		.o_ddr_cfg_start (o_ddr_cfg_start),
		.o_ddr_axi_rstn  (o_ddr_axi_rstn),
		.o_cfg_ready     (cfg_ready)
	);

	// switch 1 restarts a finished test
	mem_check_seq u_seq (
		.iSCLK (iSCLK), .qLocked (qLocked),
		.i_cfg_ready (cfg_ready), .i_restart_n (i_pb_sw[1]),
		.o_wr_start (wr_start), .o_rd_start (rd_start), .o_base (burst_base),
		.i_wr_done (wr_done), .i_wr_bad (wr_bad),
		.i_rd_done (rd_done), .i_rd_mismatch (rd_mismatch),
		.i_rd_mismatch_addr (rd_mismatch_addr),
		.o_test_run (test_run), .o_test_done (test_done),
		.o_test_fail (test_fail), .o_fail_addr (o_fail_addr)
	);

	mem_check_writer u_wr (
		.iSCLK (iSCLK), .qLocked (qLocked), .i_start (wr_start), .i_base (burst_base),
		.o_awaddr (o_awaddr), .o_awlen (o_awlen),
		.o_awvalid (o_awvalid), .i_awready (i_awready),
		.o_wdata (o_wdata), .o_wstrb (o_wstrb), .o_wlast (o_wlast),
		.o_wvalid (o_wvalid), .i_wready (i_wready),
		.i_bresp (i_bresp), .i_bvalid (i_bvalid), .o_bready (o_bready),
		.o_done (wr_done), .o_bad_resp (wr_bad)
	);

	mem_check_reader u_rd (
		.iSCLK (iSCLK), .qLocked (qLocked), .i_start (rd_start), .i_base (burst_base),
		.o_araddr (o_araddr), .o_arlen (o_arlen),
		.o_arvalid (o_arvalid), .i_arready (i_arready),
		.i_rdata (i_rdata), .i_rresp (i_rresp), .i_rlast (i_rlast),
		.i_rvalid (i_rvalid), .o_rready (o_rready),
		.o_done (rd_done), .o_mismatch (rd_mismatch),
		.o_mismatch_addr (rd_mismatch_addr)
	);

	// ------------------------------------------------------------
	// user LEDs
	// ------------------------------------------------------------
	assign o_led[2] = qLocked;
	assign o_led[3] = o_ddr_cfg_start;
	assign o_led[4] = cfg_ready;
	assign o_led[5] = test_run;
	assign o_led[6] = test_fail;
	assign o_led[7] = test_done;

endmodule

`default_nettype wire

/* source/mem_check_reader.sv */
// axi burst reader: one 8-beat read per start, each beat compared with the pattern
`timescale 1ns/1ps
`default_nettype none

module mem_check_reader (
	input  logic                        iSCLK,
	input  logic                        qLocked,
	input  logic                        i_start,
	input  fmb_pkg::addr_t              i_base,
	output fmb_pkg::addr_t              o_araddr,
	output logic [fmb_pkg::AXLEN_W-1:0] o_arlen,
	output logic                        o_arvalid,
	input  logic                        i_arready,
	input  fmb_pkg::data_t              i_rdata,
	input  logic [fmb_pkg::RESP_W-1:0]  i_rresp,
	input  logic                        i_rlast,
	input  logic                        i_rvalid,
	output logic                        o_rready,
	output logic                        o_done,
	output logic                        o_mismatch,
	output fmb_pkg::addr_t              o_mismatch_addr
);
	import fmb_pkg::*;

	addr_t beat_addr;
	logic rd_active;
	logic beat_take;
	logic beat_bad;

	assign beat_take = i_rvalid && o_rready;
	// error response is treated like wrong data
	assign beat_bad = (i_rdata != pattern_of(beat_addr)) || (|i_rresp);

	// ------------------------------------------------------------
	// burst control
	// ------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			o_arvalid <= 1'b0;
			rd_active <= 1'b0;
			o_done <= 1'b0;
			o_mismatch <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_start && !rd_active)
			begin
				o_arvalid <= 1'b1;
				rd_active <= 1'b1;
				o_mismatch <= 1'b0;
			end
			if (o_arvalid && i_arready)
				o_arvalid <= 1'b0;
			if (beat_take)
			begin
				if (beat_bad)
					o_mismatch <= 1'b1;
				// burst ends on the rlast beat
				if (i_rlast)
				begin
					rd_active <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	// beat address, first bad beat latched
	always_ff @(posedge iSCLK)
	begin
		if (i_start && !rd_active)
		begin
			o_araddr <= i_base;
			beat_addr <= i_base;
		end
		else if (beat_take)
		begin
			beat_addr <= beat_addr + addr_t'(BEAT_BYTES);
			if (beat_bad && !o_mismatch)
				o_mismatch_addr <= beat_addr;
		end
	end

	assign o_arlen = AXLEN_W'(BURST_LEN - 1);
	// ready stays up for the whole burst
	assign o_rready = rd_active;

endmodule

`default_nettype wire

/* source/mem_check_seq.sv */
// memory test sequencer: write pass then read pass over the test region, sticky status
`timescale 1ns/1ps
`default_nettype none

module mem_check_seq (
	input  logic           iSCLK,
	input  logic           qLocked,
	input  logic           i_cfg_ready,
	input  logic           i_restart_n,
	output logic           o_wr_start,
	output logic           o_rd_start,
	output fmb_pkg::addr_t o_base,
	input  logic           i_wr_done,
	input  logic           i_wr_bad,
	input  logic           i_rd_done,
	input  logic           i_rd_mismatch,
	input  fmb_pkg::addr_t i_rd_mismatch_addr,
	output logic           o_test_run,
	output logic           o_test_done,
	output logic           o_test_fail,
	output fmb_pkg::addr_t o_fail_addr
);
	import fmb_pkg::*;

	test_state_e state;
	logic [BURST_CNT_W-1:0] burst_cnt;
	logic last_burst;
	logic [2:0] sw_sync;
	logic restart_press;

	// push switch sync, press is a high to low step
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
			sw_sync <= 3'b111;
		else
			sw_sync <= {sw_sync[1:0], i_restart_n};
	end

	assign restart_press = sw_sync[2] & ~sw_sync[1];
	assign last_burst = (burst_cnt == BURST_CNT_W'(TEST_BURSTS - 1));

	// ------------------------------------------------------------
	// test FSM
	// ------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			state <= TS_IDLE;
			burst_cnt <= '0;
			o_base <= TEST_BASE;
			o_test_fail <= 1'b0;
			o_fail_addr <= '0;
		end
		else
		begin
			case (state)
				TS_IDLE:
				begin
					burst_cnt <= '0;
					o_base <= TEST_BASE;
					if (i_cfg_ready)
						state <= TS_WR_ISSUE;
				end
				TS_WR_ISSUE:
					state <= TS_WR_WAIT;
				TS_WR_WAIT:
				begin
					if (i_wr_done)
					begin
						// bad response blames the whole burst
						if (i_wr_bad && !o_test_fail)
						begin
							o_test_fail <= 1'b1;
							o_fail_addr <= o_base;
						end
						burst_cnt <= burst_cnt + 1'b1;
						if (last_burst)
						begin
							o_base <= TEST_BASE;
							state <= TS_RD_ISSUE;
						end
						else
						begin
							o_base <= o_base + addr_t'(BURST_BYTES);
							state <= TS_WR_ISSUE;
						end
					end
				end
				TS_RD_ISSUE:
					state <= TS_RD_WAIT;
				TS_RD_WAIT:
				begin
					if (i_rd_done)
					begin
						// only the first failing word is kept
						if (i_rd_mismatch && !o_test_fail)
						begin
							o_test_fail <= 1'b1;
							o_fail_addr <= i_rd_mismatch_addr;
						end
						burst_cnt <= burst_cnt + 1'b1;
						o_base <= o_base + addr_t'(BURST_BYTES);
						state <= last_burst ? TS_DONE : TS_RD_ISSUE;
					end
				end
				default:
				begin
					// restart wipes the previous result
					if (restart_press)
					begin
						o_test_fail <= 1'b0;
						o_fail_addr <= '0;
						state <= TS_IDLE;
					end
				end
			endcase
		end
	end

	// issue states last one clock, so starts are single pulses
	assign o_wr_start = (state == TS_WR_ISSUE);
	assign o_rd_start = (state == TS_RD_ISSUE);
	assign o_test_run = (state != TS_IDLE) && (state != TS_DONE);
	assign o_test_done = (state == TS_DONE);

endmodule

`default_nettype wire

/* source/mem_check_writer.sv */
// axi burst writer: one 8-beat pattern burst per start, then response check
`timescale 1ns/1ps
`default_nettype none

module mem_check_writer (
	input  logic                        iSCLK,
	input  logic                        qLocked,
	input  logic                        i_start,
	input  fmb_pkg::addr_t              i_base,
	output fmb_pkg::addr_t              o_awaddr,
	output logic [fmb_pkg::AXLEN_W-1:0] o_awlen,
	output logic                        o_awvalid,
	input  logic                        i_awready,
	output fmb_pkg::data_t              o_wdata,
	output logic [fmb_pkg::STRB_W-1:0]  o_wstrb,
	output logic                        o_wlast,
	output logic                        o_wvalid,
	input  logic                        i_wready,
	input  logic [fmb_pkg::RESP_W-1:0]  i_bresp,
	input  logic                        i_bvalid,
	output logic                        o_bready,
	output logic                        o_done,
	output logic                        o_bad_resp
);
	import fmb_pkg::*;

	logic [BEAT_CNT_W-1:0] beat_cnt;
	addr_t beat_addr;
	logic busy;

	// any channel phase still open
	assign busy = o_awvalid | o_wvalid | o_bready;

	// ------------------------------------------------------------
	// channel phases: address, data, response
	// ------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge qLocked)
	begin
		if (!qLocked)
		begin
			o_awvalid <= 1'b0;
			o_wvalid <= 1'b0;
			o_bready <= 1'b0;
			o_done <= 1'b0;
			o_bad_resp <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_start && !busy)
				o_awvalid <= 1'b1;
			// data phase opens once the address is taken
			if (o_awvalid && i_awready)
			begin
				o_awvalid <= 1'b0;
				o_wvalid <= 1'b1;
				beat_cnt <= '0;
			end
			// stalled beats simply hold
			if (o_wvalid && i_wready)
			begin
				beat_cnt <= beat_cnt + 1'b1;
				if (o_wlast)
				begin
					o_wvalid <= 1'b0;
					o_bready <= 1'b1;
				end
			end
			if (o_bready && i_bvalid)
			begin
				o_bready <= 1'b0;
				o_done <= 1'b1;
				o_bad_resp <= |i_bresp;
			end
		end
	end

	// burst and beat address
	always_ff @(posedge iSCLK)
	begin
		if (i_start && !busy)
		begin
			o_awaddr <= i_base;
			beat_addr <= i_base;
		end
		else if (o_wvalid && i_wready)
			beat_addr <= beat_addr + addr_t'(BEAT_BYTES);
	end

	assign o_awlen = AXLEN_W'(BURST_LEN - 1);
	assign o_wdata = pattern_of(beat_addr);
	assign o_wstrb = '1;
	assign o_wlast = (beat_cnt == BEAT_CNT_W'(BURST_LEN - 1));

endmodule

`default_nettype wire

/* tb.f */
source/fmb_pkg.sv
source/ddr_reset_sequencer.sv
source/mem_check_seq.sv
source/mem_check_writer.sv
source/mem_check_reader.sv
source/fmb_tester_top.sv
sim/tb_axi_mem_model.sv
sim/tb_fmb_tester.sv
